// ==== design/uart_pkg.sv ====
package uart_pkg;

  // Bit timing at 115200 baud from a 50 MHz clock.
  localparam int CLKS_PER_BIT = 434;
  localparam int HALF_BIT = 217;

  // Idle clocks between command frames.
  localparam int INTER_BYTE_GAP = 100;

  // Response start bit must show up within 20 bit times.
  localparam int RESP_TIMEOUT_CLKS = 20 * CLKS_PER_BIT;

  // Start-bit timeout plus the rest of a frame up to rx stb.
  localparam int RESP_DEADLINE_CLKS = RESP_TIMEOUT_CLKS + HALF_BIT + 10 * CLKS_PER_BIT + 4;

  localparam int CMD_W = 16;
  localparam int BYTE_W = 8;

  // Counter widths.
  localparam int BAUD_W = $clog2(CLKS_PER_BIT);
  localparam int TMR_W = $clog2(RESP_DEADLINE_CLKS);

  // Bit 15 set means write.
  typedef logic [CMD_W-1:0] cmd_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // Parity bit that makes data plus parity hold an odd count of ones.
  function automatic logic odd_parity(input byte_t d);
    return ~^d;
  endfunction

endpackage

// ==== design/uart_tx_if.sv ====
`timescale 1ns/1ps

interface uart_tx_if
  import uart_pkg::*;
();

  // Start of a frame, only while busy is low.
  logic stb;
  byte_t data;
  logic busy;

  // End of the stop bit.
  logic done;

  modport seq (
    output stb,
    output data,
    input  busy,
    input  done
  );

  modport phy (
    input  stb,
    input  data,
    output busy,
    output done
  );

endinterface

// ==== design/uart_rx_if.sv ====
`timescale 1ns/1ps

interface uart_rx_if
  import uart_pkg::*;
();

  // One pulse per completed frame.
  logic stb;
  byte_t data;
  logic parity_err;
  logic frame_err;

  modport phy (
    output stb,
    output data,
    output parity_err,
    output frame_err
  );

  modport seq (
    input stb,
    input data,
    input parity_err,
    input frame_err
  );

endinterface

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
  import uart_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  output logic   tx,
  uart_tx_if.phy link
);

  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0] bit_cnt;
  logic [9:0] shift_q;
  logic busy_q;
  logic done_q;
  logic bit_end;

  assign bit_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  assign link.busy = busy_q;
  assign link.done = done_q;

  // Bits after the start bit: data LSB first, parity, stop.
  always_ff @(posedge clk)
  begin
    if (link.stb)
    begin
      shift_q <= {1'b1, odd_parity(link.data), link.data};
    end
    else if (busy_q && bit_end)
    begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx <= 1'b1;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      if (link.stb)
      begin
        // Start bit.
        tx <= 1'b0;
        busy_q <= 1'b1;
        baud_cnt <= '0;
        bit_cnt <= '0;
      end
      else if (busy_q)
      begin
        if (bit_end)
        begin
          baud_cnt <= '0;
          if (bit_cnt == 4'd10)
          begin
            // Stop bit has run its full time.
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
          else
          begin
            tx <= shift_q[0];
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

  // Sequencer waits for the frame in flight.
  a_stb_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    link.stb |-> !link.busy);

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
  import uart_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rx,
  uart_rx_if.phy link
);

  logic [1:0] sync_q;
  logic line_q;
  logic fall;
  logic active;
  logic [BAUD_W-1:0] smp_cnt;
  logic [3:0] bit_cnt;
  logic smp_pt;
  byte_t data_q;
  logic par_q;
  logic stb_q;
  logic perr_q;
  logic ferr_q;

  assign fall = line_q & ~sync_q[1];
  assign smp_pt = active && (bit_cnt != 4'd0) && (smp_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  assign link.stb = stb_q;
  assign link.data = data_q;
  assign link.parity_err = perr_q;
  assign link.frame_err = ferr_q;

  // Line idles high, so reset gives no false edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q <= 2'b11;
      line_q <= 1'b1;
    end
    else
    begin
      sync_q <= {sync_q[0], rx};
      line_q <= sync_q[1];
    end
  end

  // Data bits arrive LSB first.
  always_ff @(posedge clk)
  begin
    if (smp_pt)
    begin
      if (bit_cnt <= 4'd8)
      begin
        data_q <= {sync_q[1], data_q[7:1]};
      end
      else if (bit_cnt == 4'd9)
      begin
        par_q <= sync_q[1];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      smp_cnt <= '0;
      bit_cnt <= '0;
      stb_q <= 1'b0;
      perr_q <= 1'b0;
      ferr_q <= 1'b0;
    end
    else
    begin
      stb_q <= 1'b0;
      if (!active)
      begin
        if (fall)
        begin
          active <= 1'b1;
          smp_cnt <= '0;
          bit_cnt <= '0;
        end
      end
      else if (bit_cnt == 4'd0)
      begin
        if (smp_cnt == BAUD_W'(HALF_BIT - 1))
        begin
          smp_cnt <= '0;
          // High at mid start bit means a glitch.
          if (sync_q[1])
            active <= 1'b0;
          else
            bit_cnt <= 4'd1;
        end
        else
        begin
          smp_cnt <= smp_cnt + 1'b1;
        end
      end
      else if (smp_pt)
      begin
        smp_cnt <= '0;
        if (bit_cnt == 4'd10)
        begin
          active <= 1'b0;
          stb_q <= 1'b1;
          ferr_q <= ~sync_q[1];
          perr_q <= (par_q != odd_parity(data_q));
        end
        else
        begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
      else
      begin
        smp_cnt <= smp_cnt + 1'b1;
      end
    end
  end

  a_stb_single: assert property (@(posedge clk) disable iff (!rst_n)
    link.stb |=> !link.stb);

endmodule

// ==== design/uart_cmd_seq.sv ====
`timescale 1ns/1ps

module uart_cmd_seq
  import uart_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  cmd_t   cmd_in,
  input  logic   cmd_vld,
  output logic   cmd_rdy,
  output logic   read_rdy,
  output byte_t  read_data,
  output logic   read_err,
  uart_tx_if.seq tx_link,
  uart_rx_if.seq rx_link
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_LO,
    S_GAP,
    S_SEND_HI,
    S_RESP_GAP,
    S_WAIT,
    S_RESULT
  } state_t;

  state_t state;
  cmd_t cmd_q;
  logic [TMR_W-1:0] cnt;
  logic tx_stb;

  assign cmd_rdy = (state == S_IDLE);
  assign tx_link.stb = tx_stb;
  assign tx_link.data = (state == S_SEND_HI) ? cmd_q[CMD_W-1:BYTE_W] : cmd_q[BYTE_W-1:0];

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      cnt <= '0;
      tx_stb <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      tx_stb <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (cmd_vld)
          begin
            state <= S_SEND_LO;
            tx_stb <= 1'b1;
          end
        end
        S_SEND_LO:
        begin
          if (tx_link.done)
          begin
            state <= S_GAP;
            cnt <= '0;
          end
        end
        S_GAP:
        begin
          cnt <= cnt + 1'b1;
          // Done and stb registers add two clocks of idle line.
          if (cnt == TMR_W'(INTER_BYTE_GAP - 3))
          begin
            state <= S_SEND_HI;
            tx_stb <= 1'b1;
          end
        end
        S_SEND_HI:
        begin
          if (tx_link.done)
          begin
            cnt <= '0;
            if (cmd_q[CMD_W-1])
              state <= S_IDLE;
            else
              state <= S_RESP_GAP;
          end
        end
        S_RESP_GAP:
        begin
          cnt <= cnt + 1'b1;
          if (cnt == TMR_W'(INTER_BYTE_GAP - 1))
            state <= S_WAIT;
        end
        S_WAIT:
        begin
          // Timeout keeps counting from the end of the command.
          cnt <= cnt + 1'b1;
          if (rx_link.stb)
          begin
            state <= S_RESULT;
            if (rx_link.parity_err || rx_link.frame_err)
            begin
              read_err <= 1'b1;
            end
            else
            begin
              read_rdy <= 1'b1;
              read_data <= rx_link.data;
            end
          end
          else if (cnt == TMR_W'(RESP_DEADLINE_CLKS - 1))
          begin
            state <= S_RESULT;
            read_err <= 1'b1;
          end
        end
        S_RESULT:
        begin
          state <= S_IDLE;
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Receiver flags and the timeout share one result slot.
  a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_rdy && read_err));

endmodule

// ==== design/uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  input  logic  rx,
  output logic  tx,
  output logic  cmd_rdy,
  output logic  read_rdy,
  output byte_t read_data,
  output logic  read_err
);

  uart_tx_if tx_bus ();
  uart_rx_if rx_bus ();

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx),
    .link  (tx_bus.phy)
  );

  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .link  (rx_bus.phy)
  );

  uart_cmd_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err),
    .tx_link   (tx_bus.seq),
    .rx_link   (rx_bus.seq)
  );

endmodule

// ==== verification/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_bridge
  import uart_pkg::*;
();

  localparam int FRAME_CLKS = 11 * CLKS_PER_BIT;
  // Worst case for one command: three frames, two gaps, response wait, margin.
  localparam int CMD_LIMIT = 3 * FRAME_CLKS + 2 * INTER_BYTE_GAP + RESP_TIMEOUT_CLKS
                             + 2 * CLKS_PER_BIT;
  localparam int N_CMDS = 10;
  localparam int WATCHDOG_NS = N_CMDS * CMD_LIMIT * 2 * 10;

  logic clk;
  logic rst_n;
  cmd_t cmd_in;
  logic cmd_vld;
  logic rx;
  logic tx;
  logic cmd_rdy;
  logic read_rdy;
  byte_t read_data;
  logic read_err;

  logic [31:0] rng_state;
  int errors;
  int n_tests;
  int n_failed;

  uart_cmd_bridge UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic cmd_t random_cmd(input logic write);
    logic [31:0] r;
    cmd_t c;
    r = next_random();
    c = r[CMD_W-1:0];
    c[CMD_W-1] = write;
    return c;
  endfunction

  function automatic byte_t random_byte();
    logic [31:0] r;
    r = next_random();
    return r[15:8];
  endfunction

  // One when the byte holds an even count of ones.
  function automatic logic expected_parity(input byte_t d);
    int ones;
    ones = 0;
    for (int i = 0; i < BYTE_W; i++)
      ones += d[i];
    return (ones % 2 == 0);
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
    begin
      $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Failure: %s at %0t", msg, $time);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (errors == errs_before)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      n_failed++;
      $display("test %s: %0d error(s)", name, errors - errs_before);
    end
  endtask

  // Decodes one frame on tx, sampling at mid-bit.
  task automatic receive_frame(output byte_t data, output logic par, output logic stop);
    int waited;
    waited = 0;
    data = '0;
    par = 1'b0;
    stop = 1'b0;
    while (tx !== 1'b0 && waited < FRAME_CLKS + INTER_BYTE_GAP + 4)
    begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0)
    begin
      report_failure("no start bit seen on tx");
      return;
    end
    repeat (HALF_BIT) @(negedge clk);
    if (tx !== 1'b0)
      report_failure("tx start bit not low at mid-bit");
    for (int i = 0; i < BYTE_W; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop = tx;
  endtask

  task automatic expect_frame(input byte_t exp);
    byte_t data;
    logic par;
    logic stop;
    receive_frame(data, par, stop);
    check_byte("tx data", data, exp);
    check_bit("tx parity", par, expected_parity(exp));
    check_bit("tx stop", stop, 1'b1);
  endtask

  task automatic send_frame(input byte_t d, input logic bad_parity, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, expected_parity(d) ^ bad_parity, d, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      @(negedge clk);
      rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
    end
    @(negedge clk);
    rx = 1'b1;
  endtask

  task automatic issue_cmd(input cmd_t c);
    @(negedge clk);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    cmd_in = c;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_bit("cmd_rdy", cmd_rdy, 1'b0);
  endtask

  // Counts result pulses until the bridge is ready again.
  task automatic watch_results(output int n_rdy, output int n_err);
    int waited;
    n_rdy = 0;
    n_err = 0;
    waited = 0;
    while (cmd_rdy !== 1'b1 && waited < CMD_LIMIT)
    begin
      @(negedge clk);
      waited++;
      if (read_rdy === 1'b1)
        n_rdy++;
      if (read_err === 1'b1)
        n_err++;
    end
    if (cmd_rdy !== 1'b1)
      report_failure("cmd_rdy did not return within the command time limit");
  endtask

  task automatic check_reset();
    int busy_clks;
    busy_clks = 0;
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("read_rdy", read_rdy, 1'b0);
    check_bit("read_err", read_err, 1'b0);
    check_byte("read_data", read_data, 8'h00);
    repeat (2 * CLKS_PER_BIT)
    begin
      @(negedge clk);
      if (read_rdy !== 1'b0 || read_err !== 1'b0 || tx !== 1'b1)
        busy_clks++;
    end
    check_count("idle clocks with activity", busy_clks, 0);
  endtask

  task automatic run_write(input cmd_t c);
    int n_rdy;
    int n_err;
    issue_cmd(c);
    fork
      begin
        expect_frame(c[7:0]);
        expect_frame(c[15:8]);
      end
      watch_results(n_rdy, n_err);
    join
    check_count("read_rdy pulses", n_rdy, 0);
    check_count("read_err pulses", n_err, 0);
  endtask

  task automatic run_read(input cmd_t c, input byte_t resp, input logic send,
                          input logic bad_parity, input logic bad_stop);
    int n_rdy;
    int n_err;
    issue_cmd(c);
    fork
      begin
        expect_frame(c[7:0]);
        expect_frame(c[15:8]);
        if (send)
        begin
          // Rest of the stop bit plus the response gap.
          repeat (HALF_BIT + INTER_BYTE_GAP + 8) @(negedge clk);
          send_frame(resp, bad_parity, bad_stop);
        end
      end
      watch_results(n_rdy, n_err);
    join
    if (send && !bad_parity && !bad_stop)
    begin
      check_count("read_rdy pulses", n_rdy, 1);
      check_count("read_err pulses", n_err, 0);
      check_byte("read_data", read_data, resp);
    end
    else
    begin
      check_count("read_rdy pulses", n_rdy, 0);
      check_count("read_err pulses", n_err, 1);
    end
  endtask

  task automatic run_busy_reject(input cmd_t c, input cmd_t other);
    int n_rdy;
    int n_err;
    int low_clks;
    low_clks = 0;
    issue_cmd(c);
    fork
      begin
        expect_frame(c[7:0]);
        expect_frame(c[15:8]);
      end
      watch_results(n_rdy, n_err);
      begin
        repeat (3 * CLKS_PER_BIT) @(negedge clk);
        check_bit("cmd_rdy", cmd_rdy, 1'b0);
        cmd_in = other;
        cmd_vld = 1'b1;
        @(negedge clk);
        cmd_vld = 1'b0;
      end
    join
    // A third frame would pull tx low here.
    repeat (FRAME_CLKS)
    begin
      @(negedge clk);
      if (tx !== 1'b1)
        low_clks++;
    end
    check_count("tx low clocks after command", low_clks, 0);
    check_count("read_rdy pulses", n_rdy, 0);
    check_count("read_err pulses", n_err, 0);
  endtask

  initial
  begin
    cmd_t c;
    int e0;
    errors = 0;
    n_tests = 0;
    n_failed = 0;
    rng_state = 32'ha22b_b4d2;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    e0 = errors;
    check_reset();
    end_test("reset state", e0);

    for (int i = 0; i < 3; i++)
    begin
      e0 = errors;
      c = random_cmd(1'b1);
      run_write(c);
      end_test($sformatf("write 0x%h", c), e0);
    end

    for (int i = 0; i < 2; i++)
    begin
      e0 = errors;
      c = random_cmd(1'b0);
      run_read(c, random_byte(), 1'b1, 1'b0, 1'b0);
      end_test($sformatf("read 0x%h", c), e0);
    end

    e0 = errors;
    run_read(random_cmd(1'b0), random_byte(), 1'b1, 1'b1, 1'b0);
    end_test("read with parity error", e0);

    e0 = errors;
    run_read(random_cmd(1'b0), random_byte(), 1'b1, 1'b0, 1'b1);
    end_test("read with low stop bit", e0);

    e0 = errors;
    run_read(random_cmd(1'b0), 8'h00, 1'b0, 1'b0, 1'b0);
    end_test("read with no response", e0);

    e0 = errors;
    run_busy_reject(random_cmd(1'b1), random_cmd(1'b1));
    end_test("busy rejection", e0);

    $display("Tests: %0d, failed: %0d, errors: %0d", n_tests, n_failed, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
design/uart_pkg.sv
design/uart_tx_if.sv
design/uart_rx_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_cmd_seq.sv
design/uart_cmd_bridge.sv
verification/tb_uart_cmd_bridge.sv

// ==== Bender.yml ====
package:
  name: uart_cmd_bridge

sources:
  - files:
      - design/uart_pkg.sv
      - design/uart_tx_if.sv
      - design/uart_rx_if.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart_cmd_seq.sv
      - design/uart_cmd_bridge.sv
  - target: test
    files:
      - verification/tb_uart_cmd_bridge.sv
